// File: Makefile
# Verilator build for the commit control unit testbench

VERILATOR ?= verilator
TOP       ?= tb_commit_cu
FILELIST  ?= commit_cu.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: commit_cu.f
+incdir+rtl
rtl/csr_pkg.sv
rtl/commit_pkg.sv
rtl/commit_dispatch.sv
rtl/commit_fsm.sv
rtl/commit_ctrl_out.sv
rtl/commit_cu.sv
verif/tb_clk_gen.sv
verif/tb_commit_cu.sv

// File: rtl/commit_config.svh
// ---------------------------------------------------------------------
// commit unit configuration
// field widths and machine-mode CSR addresses
// ---------------------------------------------------------------------

`ifndef COMMIT_CONFIG_SVH_
`define COMMIT_CONFIG_SVH_

// ---------------------------------------------------------------------
// widths
// ---------------------------------------------------------------------

`define COMMIT_CSR_ADDR_LEN     12  // CSR address space
`define COMMIT_EXCEPT_CODE_LEN  4   // mcause exception code field

// ---------------------------------------------------------------------
// machine trap CSRs
// ---------------------------------------------------------------------

// machine exception pc
`define COMMIT_CSR_MEPC         12'h341
// trap cause
`define COMMIT_CSR_MCAUSE       12'h342
// faulting address or instruction
`define COMMIT_CSR_MTVAL        12'h343

`endif // COMMIT_CONFIG_SVH_

// File: rtl/commit_ctrl_out.sv
// ---------------------------------------------------------------------
// commit output decoder
// Moore outputs of the commit FSM
// ---------------------------------------------------------------------

`include "commit_config.svh"

module commit_ctrl_out import csr_pkg::*; import commit_pkg::*; (
    input  cu_state_t   curr_state_i,
    output logic        ready_o,
    output comm_ctrl_t  comm_ctrl_o,
    output csr_req_t    csr_req_o,
    output rf_ctrl_t    rf_ctrl_o,
    output flush_ctrl_t flush_o
);

    always_comb begin : out_dec
        // inactive defaults
        ready_o     = 1'b0;
        comm_ctrl_o = '{reg_en: 1'b0, reg_clr: 1'b0, rd_sel: COMM_RD_SEL_RES,
                        jb_instr: 1'b0, csr_sel: COMM_CSR_SEL_RES};
        csr_req_o   = '{valid: 1'b0, override: 1'b0, comm_insn: CSR_INSN_NONE,
                        addr: `COMMIT_CSR_MEPC};
        rf_ctrl_o   = '0;
        flush_o     = '0;

        case (curr_state_i)
            IDLE: begin
                ready_o            = 1'b1;
                comm_ctrl_o.reg_en = 1'b1;
            end

            // -------------------------------------------------------------
            // regular commits
            // -------------------------------------------------------------
            COMMIT_INT_RF, COMMIT_LOAD, COMMIT_STORE, COMMIT_JUMP, COMMIT_BRANCH: begin
                ready_o            = 1'b1;
                comm_ctrl_o.reg_en = 1'b1;
                case (curr_state_i)
                    COMMIT_INT_RF: csr_req_o.comm_insn = CSR_INSN_INT;
                    COMMIT_LOAD:   csr_req_o.comm_insn = CSR_INSN_LOAD;
                    COMMIT_STORE:  csr_req_o.comm_insn = CSR_INSN_STORE;
                    COMMIT_JUMP:   csr_req_o.comm_insn = CSR_INSN_JUMP;
                    default:       csr_req_o.comm_insn = CSR_INSN_BRANCH;
                endcase
                // stores and branches leave rd alone
                if (curr_state_i != COMMIT_STORE && curr_state_i != COMMIT_BRANCH) begin
                    rf_ctrl_o = '1;
                end
                comm_ctrl_o.jb_instr = (curr_state_i == COMMIT_JUMP) ||
                                       (curr_state_i == COMMIT_BRANCH);
            end
            COMMIT_JUMP_MIS, COMMIT_BRANCH_MIS: begin
                comm_ctrl_o.reg_clr  = 1'b1;     // drop the wrong-path entry
                comm_ctrl_o.jb_instr = 1'b1;
                flush_o.ex_mis_flush = 1'b1;
                flush_o.issue_resume = 1'b1;
                if (curr_state_i == COMMIT_JUMP_MIS) begin
                    rf_ctrl_o           = '1;    // link address still written
                    csr_req_o.comm_insn = CSR_INSN_JUMP;
                end else begin
                    csr_req_o.comm_insn = CSR_INSN_BRANCH;
                end
            end
            COMMIT_CSR: begin
                comm_ctrl_o.reg_en   = 1'b1;
                comm_ctrl_o.rd_sel   = COMM_RD_SEL_CSR;   // old CSR value to rd
                csr_req_o.valid      = 1'b1;
                csr_req_o.comm_insn  = CSR_INSN_OTHER;
                rf_ctrl_o            = '1;
                flush_o.issue_resume = 1'b1;
            end

            // -------------------------------------------------------------
            // trap entry and return
            // -------------------------------------------------------------
            COMMIT_ECALL, COMMIT_EXCEPT: begin
                csr_req_o.valid       = 1'b1;    // pc to mepc
                csr_req_o.override    = 1'b1;
                comm_ctrl_o.csr_sel   = COMM_CSR_SEL_PC;
                if (curr_state_i == COMMIT_ECALL) begin
                    csr_req_o.comm_insn = CSR_INSN_OTHER;
                end else begin
                    flush_o.ex_mis_flush = 1'b1;
                    flush_o.except_flush = 1'b1;
                end
            end
            INT_WRITE_CODE, EXCEPT_WRITE_CODE: begin
                csr_req_o.valid    = 1'b1;
                csr_req_o.override = 1'b1;
                csr_req_o.addr     = `COMMIT_CSR_MCAUSE;
                if (curr_state_i == INT_WRITE_CODE) begin
                    comm_ctrl_o.reg_en  = 1'b1;
                    comm_ctrl_o.csr_sel = COMM_CSR_SEL_INT;
                end else begin
                    comm_ctrl_o.csr_sel = COMM_CSR_SEL_EXCEPT;
                end
            end
            EXCEPT_SAVE_ADDR, EXCEPT_SAVE_INSTR, EXCEPT_CLEAR_MTVAL: begin
                comm_ctrl_o.reg_en = 1'b1;
                csr_req_o.valid    = 1'b1;
                csr_req_o.override = 1'b1;
                csr_req_o.addr     = `COMMIT_CSR_MTVAL;
                case (curr_state_i)
                    EXCEPT_SAVE_ADDR: begin
                        comm_ctrl_o.csr_sel = COMM_CSR_SEL_RES;   // address sits in the result
                        comm_ctrl_o.rd_sel  = COMM_RD_SEL_CSR;
                    end
                    EXCEPT_SAVE_INSTR: comm_ctrl_o.csr_sel = COMM_CSR_SEL_INSN;
                    default:           comm_ctrl_o.csr_sel = COMM_CSR_SEL_ZERO;
                endcase
            end
            EXCEPT_LOAD_PC: begin
                comm_ctrl_o.rd_sel       = COMM_RD_SEL_EXCEPT;
                flush_o.fe_except_raised = 1'b1;
                flush_o.issue_resume     = 1'b1;
            end
            CLEAR_COMM_REG: comm_ctrl_o.reg_clr = 1'b1;
            COMMIT_MRET, MRET_LOAD_PC: begin
                csr_req_o.override  = 1'b1;      // read mepc
                comm_ctrl_o.csr_sel = COMM_CSR_SEL_ZERO;
                if (curr_state_i == COMMIT_MRET) begin
                    comm_ctrl_o.reg_en   = 1'b1;
                    csr_req_o.comm_insn  = CSR_INSN_OTHER;
                    flush_o.ex_mis_flush = 1'b1;
                    flush_o.except_flush = 1'b1;
                end else begin
                    flush_o.fe_except_raised = 1'b1;
                    flush_o.issue_resume     = 1'b1;
                end
            end
            default: ;   // RESET and HALT keep everything off
        endcase
    end

endmodule

// File: rtl/commit_cu.sv
// ---------------------------------------------------------------------
// commit control unit
// retires the ROB head entry, handles flushes and trap sequences
// ---------------------------------------------------------------------

module commit_cu import commit_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    // reorder buffer
    input  logic        valid_i,
    input  rob_head_t   rob_head_i,
    output logic        ready_o,
    // front end
    input  logic        fe_ready_i,
    // datapath, CSR unit, register file, flush
    output comm_ctrl_t  comm_ctrl_o,
    output csr_req_t    csr_req_o,
    output rf_ctrl_t    rf_ctrl_o,
    output flush_ctrl_t flush_o
);

    cu_state_t v_next_state;    // state started by a valid entry
    cu_state_t curr_state;

    commit_dispatch u_dispatch (
        .rob_head_i     (rob_head_i),
        .v_next_state_o (v_next_state)
    );

    commit_fsm u_fsm (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .valid_i        (valid_i),
        .v_next_state_i (v_next_state),
        .except_code_i  (rob_head_i.except_code),
        .fe_ready_i     (fe_ready_i),
        .curr_state_o   (curr_state)
    );

    commit_ctrl_out u_ctrl_out (
        .curr_state_i   (curr_state),
        .ready_o        (ready_o),
        .comm_ctrl_o    (comm_ctrl_o),
        .csr_req_o      (csr_req_o),
        .rf_ctrl_o      (rf_ctrl_o),
        .flush_o        (flush_o)
    );

endmodule

// File: rtl/commit_dispatch.sv
// ---------------------------------------------------------------------
// commit dispatch
// maps the ROB head entry to the commit state it starts
// ---------------------------------------------------------------------

module commit_dispatch import commit_pkg::*; (
    input  rob_head_t rob_head_i,
    output cu_state_t v_next_state_o
);

    always_comb begin : dispatch_dec
        case (rob_head_i.comm_type)
            COMM_TYPE_NONE:   v_next_state_o = IDLE;
            // register writers must have their result
            COMM_TYPE_INT_RF: v_next_state_o = rob_head_i.res_ready ? COMMIT_INT_RF : HALT;
            COMM_TYPE_LOAD:   v_next_state_o = rob_head_i.res_ready ? COMMIT_LOAD : HALT;
            COMM_TYPE_STORE:  v_next_state_o = rob_head_i.res_ready ? COMMIT_STORE : HALT;
            COMM_TYPE_JUMP: begin
                if (rob_head_i.mispredict) begin
                    v_next_state_o = COMMIT_JUMP_MIS;
                end else begin
                    v_next_state_o = COMMIT_JUMP;
                end
            end
            COMM_TYPE_BRANCH: begin
                if (rob_head_i.mispredict) begin
                    v_next_state_o = COMMIT_BRANCH_MIS;
                end else begin
                    v_next_state_o = COMMIT_BRANCH;
                end
            end
            COMM_TYPE_CSR:    v_next_state_o = COMMIT_CSR;
            COMM_TYPE_ECALL:  v_next_state_o = COMMIT_ECALL;
            COMM_TYPE_MRET:   v_next_state_o = COMMIT_MRET;
            COMM_TYPE_EXCEPT: v_next_state_o = COMMIT_EXCEPT;
            default:          v_next_state_o = RESET;   // unknown type
        endcase
    end

endmodule

// File: rtl/commit_fsm.sv
// ---------------------------------------------------------------------
// commit FSM
// state register and progression, including the trap sequences
// ---------------------------------------------------------------------

module commit_fsm import csr_pkg::*; import commit_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         valid_i,
    input  cu_state_t    v_next_state_i,
    input  except_code_t except_code_i,
    input  logic         fe_ready_i,
    output cu_state_t    curr_state_o
);

    cu_state_t curr_state;
    cu_state_t next_state;

    // -----------------------------------------------------------------
    // state progression
    // -----------------------------------------------------------------

    always_comb begin : fsm_next
        case (curr_state)
            RESET: next_state = IDLE;
            // single-cycle commits chain back to back
            IDLE, COMMIT_INT_RF, COMMIT_LOAD, COMMIT_STORE, COMMIT_JUMP,
            COMMIT_BRANCH: begin
                next_state = valid_i ? v_next_state_i : IDLE;
            end
            COMMIT_JUMP_MIS, COMMIT_BRANCH_MIS, COMMIT_CSR: next_state = IDLE;
            COMMIT_ECALL:   next_state = INT_WRITE_CODE;
            INT_WRITE_CODE: next_state = EXCEPT_LOAD_PC;
            COMMIT_MRET:    next_state = MRET_LOAD_PC;
            MRET_LOAD_PC:   next_state = fe_ready_i ? IDLE : MRET_LOAD_PC;
            COMMIT_EXCEPT:  next_state = EXCEPT_WRITE_CODE;
            EXCEPT_WRITE_CODE: begin
                // mtval content depends on the cause
                case (except_code_i)
                    E_I_ADDR_MISALIGNED,
                    E_I_ACCESS_FAULT,
                    E_BREAKPOINT,
                    E_LD_ADDR_MISALIGNED,
                    E_LD_ACCESS_FAULT,
                    E_ST_ADDR_MISALIGNED,
                    E_ST_ACCESS_FAULT,
                    E_INSTR_PAGE_FAULT,
                    E_LD_PAGE_FAULT,
                    E_ST_PAGE_FAULT:       next_state = EXCEPT_SAVE_ADDR;
                    E_ILLEGAL_INSTRUCTION: next_state = EXCEPT_SAVE_INSTR;
                    default:               next_state = EXCEPT_CLEAR_MTVAL;
                endcase
            end
            EXCEPT_SAVE_ADDR,
            EXCEPT_SAVE_INSTR,
            EXCEPT_CLEAR_MTVAL: next_state = EXCEPT_LOAD_PC;
            // hold until the front end takes the handler pc
            EXCEPT_LOAD_PC: next_state = fe_ready_i ? CLEAR_COMM_REG : EXCEPT_LOAD_PC;
            CLEAR_COMM_REG: next_state = IDLE;
            HALT:           next_state = HALT;
            default:        next_state = RESET;
        endcase
    end

    // -----------------------------------------------------------------
    // state register
    // -----------------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_n_i) begin : fsm_reg
        if (!rst_n_i) begin
            curr_state <= RESET;
        end else begin
            curr_state <= next_state;
        end
    end

    assign curr_state_o = curr_state;

endmodule

// File: rtl/commit_pkg.sv
// ---------------------------------------------------------------------
// commit unit types
// opcodes, FSM states, data selectors and port structs
// ---------------------------------------------------------------------

package commit_pkg;

    import csr_pkg::*;

    // commit type of the ROB head entry
    typedef enum logic [3:0] {
        COMM_TYPE_NONE,
        COMM_TYPE_INT_RF,
        COMM_TYPE_LOAD,
        COMM_TYPE_STORE,
        COMM_TYPE_JUMP,
        COMM_TYPE_BRANCH,
        COMM_TYPE_CSR,
        COMM_TYPE_ECALL,
        COMM_TYPE_MRET,
        COMM_TYPE_EXCEPT
    } comm_type_t;

    typedef enum logic [4:0] {
        RESET,
        IDLE,               // waiting for a ROB entry
        COMMIT_INT_RF,
        COMMIT_LOAD,
        COMMIT_STORE,
        COMMIT_JUMP,
        COMMIT_JUMP_MIS,    // flush after jump mispredict
        COMMIT_BRANCH,
        COMMIT_BRANCH_MIS,  // flush after branch mispredict
        COMMIT_CSR,
        COMMIT_ECALL,       // pc to mepc
        INT_WRITE_CODE,     // ecall code to mcause
        COMMIT_MRET,
        MRET_LOAD_PC,       // mepc back to the front end
        COMMIT_EXCEPT,      // pc to mepc, flush
        EXCEPT_WRITE_CODE,  // exception code to mcause
        EXCEPT_SAVE_ADDR,
        EXCEPT_SAVE_INSTR,
        EXCEPT_CLEAR_MTVAL,
        EXCEPT_LOAD_PC,     // redirect to the trap handler
        CLEAR_COMM_REG,
        HALT                // dead end, only reset leaves it
    } cu_state_t;

    // rd write-back source
    typedef enum logic [1:0] {
        COMM_RD_SEL_RES,
        COMM_RD_SEL_CSR,
        COMM_RD_SEL_EXCEPT
    } comm_rd_sel_t;

    // CSR write data source
    typedef enum logic [2:0] {
        COMM_CSR_SEL_RES,
        COMM_CSR_SEL_PC,
        COMM_CSR_SEL_INT,
        COMM_CSR_SEL_EXCEPT,
        COMM_CSR_SEL_INSN,
        COMM_CSR_SEL_ZERO
    } comm_csr_sel_t;

    typedef struct packed {
        comm_type_t   comm_type;
        logic         res_ready;
        logic         mispredict;
        except_code_t except_code;
    } rob_head_t;

    typedef struct packed {
        logic          reg_en;
        logic          reg_clr;
        comm_rd_sel_t  rd_sel;
        logic          jb_instr;
        comm_csr_sel_t csr_sel;
    } comm_ctrl_t;

    typedef struct packed {
        logic           valid;
        logic           override;   // access the CSR regardless of the instruction
        csr_comm_insn_t comm_insn;
        csr_addr_t      addr;
    } csr_req_t;

    typedef struct packed {
        logic int_rs_valid;
        logic int_rf_valid;
    } rf_ctrl_t;

    typedef struct packed {
        logic fe_except_raised;
        logic ex_mis_flush;
        logic except_flush;
        logic issue_resume;
    } flush_ctrl_t;

endpackage

// File: rtl/csr_pkg.sv
// ---------------------------------------------------------------------
// CSR types shared by the commit unit and the CSR unit
// ---------------------------------------------------------------------

`include "commit_config.svh"

package csr_pkg;

    typedef logic [`COMMIT_CSR_ADDR_LEN-1:0] csr_addr_t;

    // RISC-V synchronous exception codes
    typedef enum logic [`COMMIT_EXCEPT_CODE_LEN-1:0] {
        E_I_ADDR_MISALIGNED   = 4'd0,
        E_I_ACCESS_FAULT      = 4'd1,
        E_ILLEGAL_INSTRUCTION = 4'd2,
        E_BREAKPOINT          = 4'd3,
        E_LD_ADDR_MISALIGNED  = 4'd4,
        E_LD_ACCESS_FAULT     = 4'd5,
        E_ST_ADDR_MISALIGNED  = 4'd6,
        E_ST_ACCESS_FAULT     = 4'd7,
        E_ENV_CALL_UMODE      = 4'd8,
        E_ENV_CALL_SMODE      = 4'd9,
        E_ENV_CALL_MMODE      = 4'd11,
        E_INSTR_PAGE_FAULT    = 4'd12,
        E_LD_PAGE_FAULT       = 4'd13,
        E_ST_PAGE_FAULT       = 4'd15
    } except_code_t;

    // retiring instruction class, for the performance counters
    typedef enum logic [2:0] {
        CSR_INSN_NONE,
        CSR_INSN_INT,
        CSR_INSN_LOAD,
        CSR_INSN_STORE,
        CSR_INSN_JUMP,
        CSR_INSN_BRANCH,
        CSR_INSN_OTHER
    } csr_comm_insn_t;

endpackage

// File: verif/tb_clk_gen.sv
// ----------------------------------------------------------------------
// testbench clock and reset generator
// 40 ns clock, reset held for 4 cycles at start and on each restart
// ----------------------------------------------------------------------

module tb_clk_gen (
    input  logic restart_i,
    output logic clk_o,
    output logic rst_n_o
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin : clk_drive
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    initial begin : rst_drive
        rst_n_o = 1'b0;
        forever begin
            repeat (4) @(posedge clk_o);
            #2 rst_n_o = 1'b1;        // release just after the edge
            @(posedge restart_i);
            rst_n_o = 1'b0;           // async assert
        end
    end

endmodule

// File: verif/tb_commit_cu.sv
// ----------------------------------------------------------------------
// commit control unit testbench
// random simple commits, flushes, trap sequences and halt
// ----------------------------------------------------------------------

`include "commit_config.svh"

module tb_commit_cu import csr_pkg::*; import commit_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    logic        clk;
    logic        rst_n;
    logic        restart;
    logic        valid;
    logic        fe_ready;
    rob_head_t   rob_head;
    logic        ready;
    comm_ctrl_t  comm_ctrl;
    csr_req_t    csr_req;
    rf_ctrl_t    rf_ctrl;
    flush_ctrl_t flush;

    // acceptance history, bit k set k+1 cycles after the edge
    logic        simple_q = 1'b0;
    logic [1:0]  mis_sh = '0;
    logic [3:0]  exc_sh = '0;
    logic [2:0]  ecall_sh = '0;
    logic [1:0]  mret_sh = '0;
    comm_type_t  prev_type = COMM_TYPE_NONE;
    except_code_t prev_code = E_I_ADDR_MISALIGNED;
    logic        rst_q = 1'b0;
    logic        rst_qq = 1'b0;
    logic        trap_is_mret;
    logic        halt_expected;
    int          cycles = 0;

    logic        accept;
    logic [6:0]  reset_bits;
    logic [19:0] halt_bits;

    assign accept     = valid && ready;
    assign reset_bits = {ready, comm_ctrl.reg_en, csr_req.valid, flush};
    assign halt_bits  = {ready, comm_ctrl, csr_req.valid, csr_req.override,
                         csr_req.comm_insn, rf_ctrl, flush};

    tb_clk_gen u_clk_gen (
        .restart_i (restart),
        .clk_o     (clk),
        .rst_n_o   (rst_n)
    );

    commit_cu u_dut (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .valid_i     (valid),
        .rob_head_i  (rob_head),
        .ready_o     (ready),
        .fe_ready_i  (fe_ready),
        .comm_ctrl_o (comm_ctrl),
        .csr_req_o   (csr_req),
        .rf_ctrl_o   (rf_ctrl),
        .flush_o     (flush)
    );

    // ------------------------------------------------------------------
    // expected values
    // ------------------------------------------------------------------

    function automatic logic rf_write_expected(comm_type_t t);
        return t inside {COMM_TYPE_INT_RF, COMM_TYPE_LOAD, COMM_TYPE_JUMP};
    endfunction

    function automatic csr_comm_insn_t insn_class(comm_type_t t);
        case (t)
            COMM_TYPE_INT_RF: return CSR_INSN_INT;
            COMM_TYPE_LOAD:   return CSR_INSN_LOAD;
            COMM_TYPE_STORE:  return CSR_INSN_STORE;
            COMM_TYPE_JUMP:   return CSR_INSN_JUMP;
            default:          return CSR_INSN_BRANCH;
        endcase
    endfunction

    function automatic comm_csr_sel_t mtval_source(except_code_t c);
        case (c)
            E_ILLEGAL_INSTRUCTION: return COMM_CSR_SEL_INSN;
            E_ENV_CALL_UMODE, E_ENV_CALL_SMODE, E_ENV_CALL_MMODE: return COMM_CSR_SEL_ZERO;
            default:               return COMM_CSR_SEL_RES;   // address type codes
        endcase
    endfunction

    task automatic check_failed(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        $display("CHECK FAILED at %0t ns: %s expected %0h got %0h", $time, name, exp, act);
        $display("tests failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin : history
        simple_q  <= accept && rob_head.comm_type inside {COMM_TYPE_INT_RF, COMM_TYPE_LOAD,
                     COMM_TYPE_STORE, COMM_TYPE_JUMP, COMM_TYPE_BRANCH}
                     && rob_head.res_ready && !rob_head.mispredict;
        mis_sh    <= {mis_sh[0], accept && rob_head.mispredict &&
                      rob_head.comm_type inside {COMM_TYPE_JUMP, COMM_TYPE_BRANCH}};
        exc_sh    <= {exc_sh[2:0], accept && rob_head.comm_type == COMM_TYPE_EXCEPT};
        ecall_sh  <= {ecall_sh[1:0], accept && rob_head.comm_type == COMM_TYPE_ECALL};
        mret_sh   <= {mret_sh[0], accept && rob_head.comm_type == COMM_TYPE_MRET};
        prev_type <= rob_head.comm_type;
        if (accept && rob_head.comm_type == COMM_TYPE_EXCEPT) begin
            prev_code <= rob_head.except_code;
        end
        rst_q  <= rst_n;
        rst_qq <= rst_q;
    end

    // ------------------------------------------------------------------
    // checkers
    // ------------------------------------------------------------------

    a_reset: assert property (@(posedge clk) (!rst_n || !rst_q) |-> reset_bits == '0)
        else check_failed("ready/reg_en/csr valid/flush", 32'h0, 32'($sampled(reset_bits)));
    a_reset_ready: assert property (@(posedge clk) (rst_q && !rst_qq) |-> ready)
        else check_failed("ready_o", 32'h1, 32'($sampled(ready)));
    a_rf_valid: assert property (@(posedge clk)
        simple_q |-> rf_ctrl.int_rf_valid == rf_write_expected(prev_type))
        else check_failed("rf_ctrl_o.int_rf_valid", 32'(rf_write_expected($sampled(prev_type))),
                          32'($sampled(rf_ctrl.int_rf_valid)));
    a_jb: assert property (@(posedge clk) simple_q |->
        comm_ctrl.jb_instr == (prev_type inside {COMM_TYPE_JUMP, COMM_TYPE_BRANCH}))
        else check_failed("comm_ctrl_o.jb_instr",
            32'($sampled(prev_type) inside {COMM_TYPE_JUMP, COMM_TYPE_BRANCH}),
            32'($sampled(comm_ctrl.jb_instr)));
    a_class: assert property (@(posedge clk) simple_q |-> csr_req.comm_insn == insn_class(prev_type))
        else check_failed("csr_req_o.comm_insn", 32'(insn_class($sampled(prev_type))),
                          32'($sampled(csr_req.comm_insn)));
    a_simple_ready: assert property (@(posedge clk) simple_q |-> ready)
        else check_failed("ready_o", 32'h1, 32'($sampled(ready)));

    a_mis_flush: assert property (@(posedge clk) mis_sh[0] |->
        {flush.ex_mis_flush, flush.issue_resume, comm_ctrl.reg_clr, ready} == 4'b1110)
        else check_failed("ex_mis_flush/issue_resume/reg_clr/ready_o", 32'he,
            32'($sampled({flush.ex_mis_flush, flush.issue_resume, comm_ctrl.reg_clr, ready})));
    a_mis_ready: assert property (@(posedge clk) mis_sh[1] |-> ready)
        else check_failed("ready_o", 32'h1, 32'($sampled(ready)));

    // exception entry: mepc, mcause, then mtval
    a_exc_mepc: assert property (@(posedge clk) exc_sh[0] |->
        {csr_req.valid, csr_req.addr, comm_ctrl.csr_sel} == {1'b1, `COMMIT_CSR_MEPC, COMM_CSR_SEL_PC})
        else check_failed("csr valid/addr/csr_sel", 32'({1'b1, `COMMIT_CSR_MEPC, COMM_CSR_SEL_PC}),
            32'($sampled({csr_req.valid, csr_req.addr, comm_ctrl.csr_sel})));
    a_exc_mcause: assert property (@(posedge clk) exc_sh[1] |-> {csr_req.valid, csr_req.addr,
        comm_ctrl.csr_sel} == {1'b1, `COMMIT_CSR_MCAUSE, COMM_CSR_SEL_EXCEPT})
        else check_failed("csr valid/addr/csr_sel",
            32'({1'b1, `COMMIT_CSR_MCAUSE, COMM_CSR_SEL_EXCEPT}),
            32'($sampled({csr_req.valid, csr_req.addr, comm_ctrl.csr_sel})));
    a_exc_mtval: assert property (@(posedge clk) exc_sh[2] |-> {csr_req.addr, comm_ctrl.csr_sel}
        == {`COMMIT_CSR_MTVAL, mtval_source(prev_code)})
        else check_failed("csr addr/csr_sel",
            32'({`COMMIT_CSR_MTVAL, mtval_source($sampled(prev_code))}),
            32'($sampled({csr_req.addr, comm_ctrl.csr_sel})));
    a_exc_raise: assert property (@(posedge clk) exc_sh[3] |-> flush.fe_except_raised)
        else check_failed("flush_o.fe_except_raised", 32'h1, 32'($sampled(flush.fe_except_raised)));

    a_ecall_mepc: assert property (@(posedge clk) ecall_sh[0] |->
        {csr_req.valid, csr_req.addr, comm_ctrl.csr_sel} == {1'b1, `COMMIT_CSR_MEPC, COMM_CSR_SEL_PC})
        else check_failed("csr valid/addr/csr_sel", 32'({1'b1, `COMMIT_CSR_MEPC, COMM_CSR_SEL_PC}),
            32'($sampled({csr_req.valid, csr_req.addr, comm_ctrl.csr_sel})));
    a_ecall_mcause: assert property (@(posedge clk) ecall_sh[1] |->
        {csr_req.addr, comm_ctrl.csr_sel} == {`COMMIT_CSR_MCAUSE, COMM_CSR_SEL_INT})
        else check_failed("csr addr/csr_sel", 32'({`COMMIT_CSR_MCAUSE, COMM_CSR_SEL_INT}),
            32'($sampled({csr_req.addr, comm_ctrl.csr_sel})));
    a_ecall_raise: assert property (@(posedge clk) ecall_sh[2] |-> flush.fe_except_raised)
        else check_failed("flush_o.fe_except_raised", 32'h1, 32'($sampled(flush.fe_except_raised)));

    a_mret_flush: assert property (@(posedge clk) mret_sh[0] |->
        {flush.ex_mis_flush, flush.except_flush} == 2'b11)
        else check_failed("ex_mis_flush/except_flush", 32'h3,
            32'($sampled({flush.ex_mis_flush, flush.except_flush})));
    a_mret_raise: assert property (@(posedge clk) mret_sh[1] |->
        {flush.fe_except_raised, csr_req.addr} == {1'b1, `COMMIT_CSR_MEPC})
        else check_failed("fe_except_raised/csr addr", 32'({1'b1, `COMMIT_CSR_MEPC}),
            32'($sampled({flush.fe_except_raised, csr_req.addr})));

    // front-end back-pressure and the end of each trap
    a_pc_hold: assert property (@(posedge clk)
        (flush.fe_except_raised && !fe_ready) |=> flush.fe_except_raised)
        else check_failed("flush_o.fe_except_raised", 32'h1, 32'($sampled(flush.fe_except_raised)));
    a_trap_end: assert property (@(posedge clk)
        (flush.fe_except_raised && fe_ready && !trap_is_mret) |=> comm_ctrl.reg_clr)
        else check_failed("comm_ctrl_o.reg_clr", 32'h1, 32'($sampled(comm_ctrl.reg_clr)));
    a_mret_end: assert property (@(posedge clk)
        (flush.fe_except_raised && fe_ready && trap_is_mret) |=> ready)
        else check_failed("ready_o", 32'h1, 32'($sampled(ready)));
    a_halt: assert property (@(posedge clk) halt_expected |-> halt_bits == '0)
        else check_failed("all outputs in halt", 32'h0, 32'($sampled(halt_bits)));

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------

    task automatic send_entry(input comm_type_t t, input logic res_ready,
                              input logic mis, input except_code_t code);
        logic was_ready;
        valid    = 1'b1;
        rob_head = '{comm_type: t, res_ready: res_ready, mispredict: mis, except_code: code};
        do begin
            was_ready = ready;     // Moore output, stable here
            @(posedge clk);
            #2;
        end while (!was_ready);
        valid = 1'b0;              // entry fields stay, ROB holds except_code
    endtask

    task automatic run_trap(input comm_type_t t, input except_code_t code);
        int stall;
        stall        = $urandom % 6;
        trap_is_mret = (t == COMM_TYPE_MRET);
        fe_ready     = 1'b0;
        send_entry(t, 1'b1, 1'b0, code);
        while (!flush.fe_except_raised) begin
            @(posedge clk);
            #2;
        end
        repeat (stall) begin
            @(posedge clk);
            #2;
        end
        fe_ready = 1'b1;
        while (flush.fe_except_raised) begin   // front end takes the new pc
            @(posedge clk);
            #2;
        end
    endtask

    always @(posedge clk) begin : watchdog
        cycles <= cycles + 1;
        if (cycles >= 600) begin
            $display("timeout: run did not finish within 600 cycles");
            $display("tests failed");
            $fatal(1);
        end
    end

    initial begin : stimulus
        logic [3:0] pick;
        int         seed_val;
        seed_val      = $urandom(9648);
        valid         = 1'b0;
        rob_head      = '0;
        fe_ready      = 1'b1;
        restart       = 1'b0;
        trap_is_mret  = 1'b0;
        halt_expected = 1'b0;
        wait (rst_n);
        repeat (200) begin
            pick = 4'($urandom % 5);
            send_entry(comm_type_t'(pick + 4'd1), 1'b1, 1'b0, E_I_ADDR_MISALIGNED);
        end
        send_entry(COMM_TYPE_JUMP, 1'b1, 1'b1, E_I_ADDR_MISALIGNED);
        send_entry(COMM_TYPE_BRANCH, 1'b1, 1'b1, E_I_ADDR_MISALIGNED);
        run_trap(COMM_TYPE_EXCEPT, E_LD_ADDR_MISALIGNED);
        run_trap(COMM_TYPE_EXCEPT, E_ILLEGAL_INSTRUCTION);
        run_trap(COMM_TYPE_EXCEPT, E_ENV_CALL_MMODE);
        run_trap(COMM_TYPE_EXCEPT, E_ST_PAGE_FAULT);
        run_trap(COMM_TYPE_ECALL, E_ENV_CALL_MMODE);
        run_trap(COMM_TYPE_MRET, E_I_ADDR_MISALIGNED);
        // load without its result locks the unit up
        send_entry(COMM_TYPE_LOAD, 1'b0, 1'b0, E_I_ADDR_MISALIGNED);
        halt_expected = 1'b1;
        repeat (20) @(posedge clk);
        #2;
        halt_expected = 1'b0;
        restart       = 1'b1;
        #1 restart    = 1'b0;
        wait (rst_n);
        while (!ready) begin
            @(posedge clk);
            #2;
        end
        repeat (2) @(posedge clk);
        $display("all tests passed");
        $finish;
    end

endmodule
